// ==== sources.f ====
rtl/rv_data_pkg.sv
rtl/data_mem_if.sv
rtl/load_store_unit.sv
rtl/data_memory_bus.sv
rtl/data_memory.sv
rtl/mmio_port.sv
rtl/data_subsystem_top.sv
verif/tb_data_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the data subsystem testbench.
# Any variable can be overridden on the command line.

VERILATOR       ?= verilator
TOP             ?= tb_data_subsystem
FILE_LIST       ?= sources.f
BUILD_DIR       ?= obj_dir
LOG_FILE        ?= simulate.log
VERILATOR_FLAGS ?= --binary --timing
PASS_TEXT       ?= test passed

.PHONY: simulate clean

# Build, run, and fail unless the log holds the pass line.
simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG_FILE)
	grep -q "^$(PASS_TEXT)$$" $(LOG_FILE)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)

// ==== verif/tb_data_subsystem.sv ====
/*
  Directed testbench for the data side of the core. Drives loads and
  stores into the top level and checks every response against a byte
  model of the RAM and of the output register.
*/
module tb_data_subsystem import rv_data_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam word_t       DATA_BEGIN   = 32'h0001_0000;  // Matches the DUT defaults.
  localparam int unsigned DATA_WORDS   = 256;
  localparam word_t       MMIO_ADDRESS = 32'h0002_0000;
  localparam int unsigned RAM_BYTES    = 4 * DATA_WORDS;
  localparam int          CYCLE_LIMIT  = 2000;           // Far above the length of all tests.

  typedef logic [$clog2(RAM_BYTES)-1:0] ram_index_t;     // Byte slot in the RAM model.

  logic   clock;
  logic   reset;
  word_t  address;
  width_t width;
  logic   read_enable;
  logic   write_enable;
  word_t  store_data;
  word_t  load_data;
  logic   misaligned;
  word_t  gpio_out;

  logic [7:0]  ram_model [RAM_BYTES];  // Expected RAM contents, one entry per byte.
  data_word_t  gpio_model;             // Expected output register.
  logic [31:0] lfsr_state;             // Random source for store values.
  int          error_count;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;

  data_subsystem_top i_dut (
    .clock        (clock),
    .reset        (reset),
    .address      (address),
    .width        (width),
    .read_enable  (read_enable),
    .write_enable (write_enable),
    .store_data   (store_data),
    .load_data    (load_data),
    .misaligned   (misaligned),
    .gpio_out     (gpio_out)
  );

  // 8 ns clock period.
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Ends a run that never reaches its summary.
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles before all tests finished", cycle_count);
    $display("test failed");
    $finish;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // Collects one fresh bit per LFSR step.
  function automatic word_t random_bits(int unsigned count);
    word_t value;
    value = '0;
    for (int unsigned i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Halfwords want an even address and words a multiple of four.
  function automatic logic predict_misaligned(word_t addr, width_t size);
    logic half;
    logic full;
    half = (size == FUNCT3_LH) || (size == FUNCT3_LHU);
    full = (size == FUNCT3_LW);
    return (half && addr[0]) || (full && (addr[1:0] != 2'b00));
  endfunction

  function automatic logic in_ram(word_t addr);
    return (addr >= DATA_BEGIN) && (addr < DATA_BEGIN + word_t'(RAM_BYTES));
  endfunction

  function automatic logic in_mmio(word_t addr);
    return addr[31:2] == MMIO_ADDRESS[31:2];  // Any byte of the register word.
  endfunction

  // Applies a store to the model the way the memory map says it lands.
  task automatic model_store(word_t addr, width_t size, word_t data);
    data_word_t  placed;
    int unsigned count;
    word_t       base;
    placed.word = data;
    count       = (size == FUNCT3_SB) ? 1 : ((size == FUNCT3_SH) ? 2 : 4);
    base        = addr - DATA_BEGIN;
    if (!predict_misaligned(addr, size)) begin
      for (int unsigned i = 0; i < count; i++) begin
        if (in_ram(addr)) begin
          ram_model[ram_index_t'(base + word_t'(i))] = placed.bytes[2'(i)];
        end else if (in_mmio(addr)) begin
          gpio_model.bytes[addr[1:0] + 2'(i)] = placed.bytes[2'(i)];
        end
      end
    end
  endtask

  // Expected load result from the model contents.
  function automatic word_t predict_load(word_t addr, width_t size);
    data_word_t  fetched;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    word_t       base;
    fetched.word = '0;  // Unmapped and dropped accesses read zero.
    base         = {addr[31:2], 2'b00} - DATA_BEGIN;
    if (predict_misaligned(addr, size)) begin
      return '0;
    end
    if (in_ram(addr)) begin
      for (int lane = 0; lane < 4; lane++) begin
        fetched.bytes[2'(lane)] = ram_model[ram_index_t'(base + word_t'(lane))];
      end
    end else if (in_mmio(addr)) begin
      fetched.word = gpio_model.word;
    end
    lane_byte = fetched.bytes[addr[1:0]];
    lane_half = fetched.halves[addr[1]];
    case (size)
      FUNCT3_LB:  return {{24{lane_byte[7]}}, lane_byte};
      FUNCT3_LH:  return {{16{lane_half[15]}}, lane_half};
      FUNCT3_LW:  return fetched.word;
      FUNCT3_LBU: return {24'h0, lane_byte};
      FUNCT3_LHU: return {16'h0, lane_half};
      default:    return '0;
    endcase
  endfunction

  task automatic compare_word(string signal, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%08h, got 0x%08h at %0t", signal, expected, actual, $time);
      error_count++;
    end
  endtask

  task automatic compare_flag(string signal, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%h, got 0x%h at %0t", signal, expected, actual, $time);
      error_count++;
    end
  endtask

  // One store request. It commits at the edge that starts the next access.
  task automatic issue_store(word_t addr, width_t size, word_t data);
    @(posedge clock);
    address      <= addr;
    width        <= size;
    read_enable  <= 1'b0;
    write_enable <= 1'b1;
    store_data   <= data;
    @(negedge clock);  // Outputs have settled mid-cycle.
    compare_flag("misaligned", predict_misaligned(addr, size), misaligned);
    model_store(addr, size, data);
  endtask

  // One load request, answered in the same cycle.
  task automatic issue_load(word_t addr, width_t size);
    @(posedge clock);
    address      <= addr;
    width        <= size;
    read_enable  <= 1'b1;
    write_enable <= 1'b0;
    @(negedge clock);
    compare_flag("misaligned", predict_misaligned(addr, size), misaligned);
    compare_word("load_data", predict_load(addr, size), load_data);
  endtask

  task automatic drive_idle();
    @(posedge clock);
    read_enable  <= 1'b0;
    write_enable <= 1'b0;
  endtask

  // The register shows a store one cycle after its edge.
  task automatic check_gpio();
    drive_idle();
    @(negedge clock);
    compare_word("gpio_out", gpio_model.word, gpio_out);
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset        <= 1'b1;
    read_enable  <= 1'b0;
    write_enable <= 1'b0;
    repeat (3) @(posedge clock);
    reset           <= 1'b0;
    gpio_model.word = '0;  // The RAM keeps its contents.
  endtask

  task automatic report_test(string name, int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("[ok]     %s", name);
    end else begin
      tests_failed++;
      $display("[FAILED] %s with %0d mismatches", name, error_count - errors_before);
    end
  endtask

  task automatic output_register();
    int errors_before;
    errors_before = error_count;
    @(negedge clock);
    compare_word("gpio_out", 32'h0, gpio_out);  // Straight out of the first reset.
    issue_store(MMIO_ADDRESS, FUNCT3_SW, random_bits(32));
    check_gpio();
    issue_store(MMIO_ADDRESS + 32'd2, FUNCT3_SB, random_bits(32));
    check_gpio();
    issue_store(MMIO_ADDRESS + 32'd1, FUNCT3_SB, random_bits(32));
    check_gpio();
    issue_load(MMIO_ADDRESS, FUNCT3_LW);
    issue_load(MMIO_ADDRESS + 32'd2, FUNCT3_LBU);
    apply_reset();
    @(negedge clock);
    compare_word("gpio_out", gpio_model.word, gpio_out);
    report_test("output register", errors_before);
  endtask

  task automatic word_round_trip();
    int    errors_before;
    word_t addr;
    errors_before = error_count;
    for (int n = 0; n < 16; n++) begin
      addr = DATA_BEGIN + (random_bits(8) << 2);  // Any aligned RAM word.
      issue_store(addr, FUNCT3_SW, random_bits(32));
      issue_load(addr, FUNCT3_LW);
    end
    report_test("word round trip", errors_before);
  endtask

  task automatic subword_access();
    int    errors_before;
    word_t base;
    word_t data;
    errors_before = error_count;
    base          = DATA_BEGIN + 32'h0000_0040;
    issue_store(base, FUNCT3_SW, random_bits(32));
    for (int lane = 0; lane < 4; lane++) begin
      data    = random_bits(7);
      data[7] = lane[0];  // Odd lanes carry a negative byte.
      issue_store(base + word_t'(lane), FUNCT3_SB, data);
      issue_load(base, FUNCT3_LW);  // Only the addressed lane may change.
      issue_load(base + word_t'(lane), FUNCT3_LB);
      issue_load(base + word_t'(lane), FUNCT3_LBU);
    end
    for (int half = 0; half < 2; half++) begin
      data     = random_bits(15);
      data[15] = half[0];
      issue_store(base + word_t'(2 * half), FUNCT3_SH, data);
      issue_load(base, FUNCT3_LW);
      issue_load(base + word_t'(2 * half), FUNCT3_LH);
      issue_load(base + word_t'(2 * half), FUNCT3_LHU);
    end
    report_test("sub-word access", errors_before);
  endtask

  // The outside addresses alias the first and last RAM words in the low
  // address bits, so a leaky decode would corrupt them.
  task automatic region_decode();
    int    errors_before;
    word_t first;
    word_t last;
    errors_before = error_count;
    first         = DATA_BEGIN;
    last          = DATA_BEGIN + word_t'(RAM_BYTES) - 32'd4;
    issue_store(first, FUNCT3_SW, random_bits(32));
    issue_store(last, FUNCT3_SW, random_bits(32));
    issue_store(DATA_BEGIN - 32'd4, FUNCT3_SW, random_bits(32));
    issue_store(DATA_BEGIN - 32'd1, FUNCT3_SB, random_bits(32));
    issue_store(last + 32'd4, FUNCT3_SW, random_bits(32));
    check_gpio();
    issue_load(first, FUNCT3_LW);
    issue_load(last, FUNCT3_LW);
    issue_load(DATA_BEGIN - 32'd4, FUNCT3_LW);  // Nothing mapped here.
    issue_load(last + 32'd4, FUNCT3_LW);
    report_test("region decode", errors_before);
  endtask

  task automatic misaligned_access();
    int    errors_before;
    word_t base;
    errors_before = error_count;
    base          = DATA_BEGIN + 32'h0000_0080;
    issue_store(base, FUNCT3_SW, random_bits(32));
    issue_store(base + 32'd1, FUNCT3_SH, random_bits(32));
    issue_store(base + 32'd3, FUNCT3_SH, random_bits(32));
    for (int offset = 1; offset < 4; offset++) begin
      issue_store(base + word_t'(offset), FUNCT3_SW, random_bits(32));
    end
    issue_load(base, FUNCT3_LW);  // Still the first word written.
    issue_load(base + 32'd1, FUNCT3_LH);
    issue_load(base + 32'd2, FUNCT3_LW);
    issue_load(base + 32'd2, FUNCT3_LHU);
    issue_store(base + 32'd3, FUNCT3_SB, random_bits(32));
    issue_load(base, FUNCT3_LW);
    report_test("misaligned access", errors_before);
  endtask

  initial begin
    lfsr_state      = 32'd98288;
    error_count     = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    gpio_model.word = '0;
    reset           <= 1'b1;
    address         <= '0;
    width           <= FUNCT3_LW;
    read_enable     <= 1'b0;
    write_enable    <= 1'b0;
    store_data      <= '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    output_register();
    word_round_trip();
    subword_access();
    region_decode();
    misaligned_access();

    $display("Summary: %0d tests ok, %0d failing, %0d mismatches",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== rtl/data_subsystem_top.sv ====
/*
  Data side of a single-cycle RISC-V core. Load-store unit, address
  decode, data RAM and one memory-mapped output register.
*/
module data_subsystem_top import rv_data_pkg::*; #(
  parameter word_t       DATA_BEGIN   = 32'h0001_0000,  // RAM base byte address.
  parameter int unsigned DATA_WORDS   = 256,            // RAM depth in words.
  parameter word_t       MMIO_ADDRESS = 32'h0002_0000   // Output register address.
) (
  input  logic   clock,
  input  logic   reset,
  input  word_t  address,       // Byte address of the load or store.
  input  width_t width,         // funct3 of the instruction.
  input  logic   read_enable,   // Load strobe.
  input  logic   write_enable,  // Store strobe.
  input  word_t  store_data,    // Value to store.
  output word_t  load_data,     // Load result, same cycle.
  output logic   misaligned,    // Request was dropped for alignment.
  output word_t  gpio_out       // Output register pins.
);

  data_mem_if core_if ();  // Load-store unit to bus.
  data_mem_if ram_if ();   // Bus to RAM.
  data_mem_if mmio_if ();  // Bus to output register.

  load_store_unit i_load_store_unit (
    .width      (width),
    .address    (address),
    .load       (read_enable),
    .store      (write_enable),
    .store_data (store_data),
    .load_data  (load_data),
    .misaligned (misaligned),
    .mem        (core_if)
  );

  data_memory_bus #(
    .DATA_BEGIN   (DATA_BEGIN),
    .DATA_WORDS   (DATA_WORDS),
    .MMIO_ADDRESS (MMIO_ADDRESS)
  ) i_data_memory_bus (
    .core (core_if),
    .ram  (ram_if),
    .mmio (mmio_if)
  );

  data_memory #(
    .DATA_WORDS (DATA_WORDS)
  ) i_data_memory (
    .clock (clock),
    .bus   (ram_if)
  );

  mmio_port i_mmio_port (
    .clock    (clock),
    .reset    (reset),
    .bus      (mmio_if),
    .gpio_out (gpio_out)
  );

endmodule

// ==== rtl/mmio_port.sv ====
/*
  Memory-mapped output register with byte-enabled writes and readback.
  The stored word drives the gpio pins.
*/
module mmio_port import rv_data_pkg::*; (
  input  logic      clock,
  input  logic      reset,     // Synchronous, clears the register.
  data_mem_if.slave bus,
  output word_t     gpio_out   // Current register value.
);

  word_t output_word;  // The register itself.

  // Merge written lanes into the held value. Unwritten lanes keep theirs.
  always_ff @(posedge clock) begin
    if (reset) begin
      output_word <= '0;
    end else if (bus.write_enable) begin
      for (int lane = 0; lane < BYTE_LANES; lane++) begin
        if (bus.byte_enable[lane]) begin
          output_word[lane*8 +: 8] <= bus.write_data[lane*8 +: 8];
        end
      end
    end
  end

  assign gpio_out      = output_word;                           // Pins follow the register.
  assign bus.read_data = bus.read_enable ? output_word : '0;  // Readback of the pins.

endmodule

// ==== rtl/data_memory.sv ====
/*
  Word-organized data RAM with per-byte write enables.
  Writes land on the rising edge; reads are combinational.
*/
module data_memory import rv_data_pkg::*; #(
  parameter int unsigned DATA_WORDS = 256  // Depth in words, a power of two.
) (
  input logic       clock,
  data_mem_if.slave bus
);

  localparam int unsigned INDEX_BITS = $clog2(DATA_WORDS);

  word_t                 storage [DATA_WORDS];  // Contents survive reset.
  logic [INDEX_BITS-1:0] index;                 // Word slot of the access.

  // The byte address drops its lane bits.
  // The bits above the depth are already checked by the bus decode.
  assign index = bus.address[INDEX_BITS+1:2];

  // Each enabled lane takes its byte of the write data.
  always_ff @(posedge clock) begin
    if (bus.write_enable) begin
      for (int lane = 0; lane < BYTE_LANES; lane++) begin
        if (bus.byte_enable[lane]) begin
          storage[index][lane*8 +: 8] <= bus.write_data[lane*8 +: 8];
        end
      end
    end
  end

  // Read port. A write in this cycle shows up after the edge.
  assign bus.read_data = bus.read_enable ? storage[index] : '0;

endmodule

// ==== rtl/data_memory_bus.sv ====
/*
  Data memory bus. Decodes the byte address into the RAM region or the
  output register, forwards the strobes to that target only and returns
  its read data.
*/
module data_memory_bus import rv_data_pkg::*; #(
  parameter word_t       DATA_BEGIN   = 32'h0001_0000,  // First RAM byte.
  parameter int unsigned DATA_WORDS   = 256,            // RAM depth in words.
  parameter word_t       MMIO_ADDRESS = 32'h0002_0000   // Output register word.
) (
  data_mem_if.slave  core,
  data_mem_if.master ram,
  data_mem_if.master mmio
);

  // Last byte address that still falls inside the RAM.
  localparam word_t DATA_END = DATA_BEGIN + word_t'(4 * DATA_WORDS) - 32'd1;

  logic ram_select;   // Address lies in the RAM window.
  logic mmio_select;  // Address lies in the output register word.

  assign ram_select  = (core.address >= DATA_BEGIN) && (core.address <= DATA_END);
  assign mmio_select = (core.address[31:2] == MMIO_ADDRESS[31:2]);  // Any byte of the word.

  // The RAM gets the access only when its window is hit.
  assign ram.address      = core.address;
  assign ram.read_enable  = core.read_enable && ram_select;
  assign ram.write_enable = core.write_enable && ram_select;
  assign ram.byte_enable  = core.byte_enable;
  assign ram.write_data   = core.write_data;

  // The output register likewise.
  assign mmio.address      = core.address;
  assign mmio.read_enable  = core.read_enable && mmio_select;
  assign mmio.write_enable = core.write_enable && mmio_select;
  assign mmio.byte_enable  = core.byte_enable;
  assign mmio.write_data   = core.write_data;

  // Return the word of whichever target was hit.
  // Unmapped addresses read as zero.
  always_comb begin
    if (ram_select) begin
      core.read_data = ram.read_data;
    end else if (mmio_select) begin
      core.read_data = mmio.read_data;
    end else begin
      core.read_data = '0;
    end
  end

endmodule

// ==== rtl/load_store_unit.sv ====
/*
  Load-store unit. Turns a core load or store into a byte-enabled word
  access, flags misaligned halfword and word accesses, and aligns and
  extends the word that comes back from memory.
*/
module load_store_unit import rv_data_pkg::*; (
  input  width_t     width,       // funct3 of the instruction.
  input  word_t      address,     // Byte address from the ALU.
  input  logic       load,        // Load request.
  input  logic       store,       // Store request.
  input  word_t      store_data,  // Register value to store.
  output word_t      load_data,   // Aligned and extended load result.
  output logic       misaligned,  // Access does not fit its natural alignment.
  data_mem_if.master mem
);

  logic [1:0]   offset;         // Byte position inside the word.
  logic         half_access;    // Request moves a halfword.
  logic         word_access;    // Request moves a full word.
  data_word_t   store_lanes;    // Store value shifted onto its lanes.
  byte_enable_t lane_mask;      // Lanes touched by the store.
  data_word_t   fetched;        // Word returned by the bus.
  logic [7:0]   selected_byte;  // Byte picked from the fetched word.
  logic [15:0]  selected_half;  // Halfword picked from the fetched word.

  assign offset = address[1:0];

  // Size of the request. Loads and stores share the low width codes, so
  // the strobe decides which table applies.
  always_comb begin
    half_access = 1'b0;
    word_access = 1'b0;
    if (store) begin
      half_access = (width == FUNCT3_SH);
      word_access = (width == FUNCT3_SW);
    end else if (load) begin
      half_access = (width == FUNCT3_LH) || (width == FUNCT3_LHU);
      word_access = (width == FUNCT3_LW);
    end
  end

  // A halfword needs an even address and a word needs a multiple of four.
  assign misaligned = (half_access && offset[0]) || (word_access && (offset != 2'b00));

  // Place the store value on the lanes named by the low address bits.
  always_comb begin
    store_lanes.word = '0;
    lane_mask        = '0;
    case (width)
      FUNCT3_SB: begin
        store_lanes.bytes[offset] = store_data[7:0];  // One byte lane.
        lane_mask[offset]         = 1'b1;
      end
      FUNCT3_SH: begin
        store_lanes.halves[offset[1]] = store_data[15:0];  // Upper or lower half.
        lane_mask = offset[1] ? 4'b1100 : 4'b0011;
      end
      FUNCT3_SW: begin
        store_lanes.word = store_data;
        lane_mask        = 4'b1111;
      end
      default: begin
        lane_mask = '0;  // Unknown codes write nothing.
      end
    endcase
  end

  // A misaligned request never reaches the bus.
  assign mem.address      = address;
  assign mem.read_enable  = load && !misaligned;
  assign mem.write_enable = store && !misaligned;
  assign mem.byte_enable  = lane_mask;
  assign mem.write_data   = store_lanes.word;

  // Pick the addressed lane out of the returned word.
  assign fetched       = data_word_t'(mem.read_data);
  assign selected_byte = fetched.bytes[offset];
  assign selected_half = fetched.halves[offset[1]];

  // Extend the picked lane to a full register value.
  always_comb begin
    case (width)
      FUNCT3_LB:  load_data = {{24{selected_byte[7]}}, selected_byte};   // Sign-extended.
      FUNCT3_LH:  load_data = {{16{selected_half[15]}}, selected_half};
      FUNCT3_LW:  load_data = fetched.word;
      FUNCT3_LBU: load_data = {24'b0, selected_byte};                   // Zero-extended.
      FUNCT3_LHU: load_data = {16'b0, selected_half};
      default:    load_data = '0;
    endcase
  end

endmodule

// ==== rtl/data_mem_if.sv ====
/*
  One byte-enabled word access between a master and a slave.
  Writes commit on the clock edge; read data returns in the same cycle.
*/
interface data_mem_if import rv_data_pkg::*; ();

  word_t        address;       // Byte address of the access.
  logic         read_enable;   // Read strobe.
  logic         write_enable;  // Write strobe, committed at the rising edge.
  byte_enable_t byte_enable;   // Lanes written by a store.
  word_t        write_data;    // Store value already placed on its lanes.
  word_t        read_data;     // Zero when the slave is not reading.

  // The requester drives the access and receives the read word.
  modport master (
    output address, read_enable, write_enable, byte_enable, write_data,
    input  read_data
  );

  // The target sees the access and answers with the read word.
  modport slave (
    input  address, read_enable, write_enable, byte_enable, write_data,
    output read_data
  );

endinterface

// ==== rtl/rv_data_pkg.sv ====
/*
  Shared data-side types for the RISC-V load/store path.
  Holds the funct3 width codes, the word and byte-enable types and the
  lane-addressable data word used to place and pick sub-word values.
*/
package rv_data_pkg;

  // One data value or one byte address.
  typedef logic [31:0] word_t;

  // Number of byte lanes in a data word.
  localparam int unsigned BYTE_LANES = 4;

  // One enable bit per byte lane; bit 0 is the least significant byte.
  typedef logic [BYTE_LANES-1:0] byte_enable_t;

  // The funct3 field of a load or store instruction.
  typedef logic [2:0] width_t;

  // Load width codes.
  localparam width_t FUNCT3_LB  = 3'b000;  // Signed byte.
  localparam width_t FUNCT3_LH  = 3'b001;  // Signed halfword.
  localparam width_t FUNCT3_LW  = 3'b010;  // Full word.
  localparam width_t FUNCT3_LBU = 3'b100;  // Unsigned byte.
  localparam width_t FUNCT3_LHU = 3'b101;  // Unsigned halfword.

  // Store width codes. They share their encoding with the signed loads
  // and are told apart by the store strobe.
  localparam width_t FUNCT3_SB  = 3'b000;
  localparam width_t FUNCT3_SH  = 3'b001;
  localparam width_t FUNCT3_SW  = 3'b010;

  // A memory word seen three ways.
  // The same 32 bits can be handled as a whole word, as two halfwords
  // selected by address bit 1, or as four bytes selected by bits 1:0.
  // Element 0 of each array is the least significant lane, which matches
  // the little-endian byte order of RISC-V.
  typedef union packed {
    word_t                 word;    // Whole word view.
    logic [1:0][15:0]      halves;  // Halfword lanes.
    logic [3:0][7:0]       bytes;   // Byte lanes.
  } data_word_t;

endpackage
